/* project.f */
+incdir+include
verilog/dramGeometryPkg.sv
verilog/rankSchedPkg.sv
verilog/requestQueue.sv
verilog/openRowTable.sv
verilog/refreshTimer.sv
verilog/issueArbiter.sv
verilog/rankScheduler.sv
verification/rankSchedTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the scheduler testbench with Verilator, run it, then grep the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module rankSchedTb -o rankSchedSim \
    && ./obj_dir/rankSchedSim | tee sim.log
grep -q "^Verification passed$" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* include/schedCases.svh */
`ifndef SCHED_CASES_SVH
`define SCHED_CASES_SVH

function automatic void buildCaseTable();
    // Columns are step name, step kind, bank, row, write flag, value and aux
    // Value holds the idle mask, write mode, cycle count, page state or read count
    // Aux holds the write count of a count check
    // --------------------
    // Queue fill with every bank busy
    addStep("busy",          STEP_IDLE,    0,  0,     0, 'h0000, 0);
    addStep("fill0",         STEP_PUSH,    0,  'h010, 0, 0, 0);
    addStep("fill1",         STEP_PUSH,    5,  'h020, 0, 0, 0);
    addStep("fill2",         STEP_PUSH,    10, 'h030, 0, 0, 0);
    addStep("fill3",         STEP_PUSH,    15, 'h040, 0, 0, 0);
    addStep("fill4",         STEP_PUSH,    3,  'h050, 0, 0, 0);
    addStep("fill5",         STEP_PUSH,    6,  'h060, 0, 0, 0);
    addStep("fill6",         STEP_PUSH,    9,  'h070, 0, 0, 0);
    addStep("fill7",         STEP_PUSH,    12, 'h080, 0, 0, 0);
    addStep("full",          STEP_COUNTS,  0,  0,     0, 8, 0);
    // --------------------
    // Oldest first while nothing is open yet
    addStep("releaseAll",    STEP_IDLE,    0,  0,     0, 'hFFFF, 0);
    addStep("oldest0",       STEP_EXPECT,  0,  'h010, 0, PAGE_EMPTY, 0);
    addStep("oldest1",       STEP_EXPECT,  5,  'h020, 0, PAGE_EMPTY, 0);
    addStep("oldest2",       STEP_EXPECT,  10, 'h030, 0, PAGE_EMPTY, 0);
    addStep("oldest3",       STEP_EXPECT,  15, 'h040, 0, PAGE_EMPTY, 0);
    addStep("oldest4",       STEP_EXPECT,  3,  'h050, 0, PAGE_EMPTY, 0);
    addStep("oldest5",       STEP_EXPECT,  6,  'h060, 0, PAGE_EMPTY, 0);
    addStep("oldest6",       STEP_EXPECT,  9,  'h070, 0, PAGE_EMPTY, 0);
    addStep("oldest7",       STEP_EXPECT,  12, 'h080, 0, PAGE_EMPTY, 0);
    addStep("drained",       STEP_COUNTS,  0,  0,     0, 0, 0);
    // --------------------
    // Row hits where bank 1 sets the last bank group to 0
    addStep("openRow",       STEP_PUSH,    1,  'h100, 0, 0, 0);
    addStep("openIssue",     STEP_EXPECT,  1,  'h100, 0, PAGE_EMPTY, 0);
    addStep("holdHits",      STEP_IDLE,    0,  0,     0, 'h0000, 0);
    addStep("missPush",      STEP_PUSH,    1,  'h200, 0, 0, 0);
    addStep("shortPush",     STEP_PUSH,    1,  'h100, 0, 0, 0);
    addStep("longPush",      STEP_PUSH,    5,  'h020, 0, 0, 0);
    addStep("releaseHits",   STEP_IDLE,    0,  0,     0, 'hFFFF, 0);
    addStep("shortFirst",    STEP_EXPECT,  1,  'h100, 0, PAGE_HIT_SHORT, 0);
    addStep("longNext",      STEP_EXPECT,  5,  'h020, 0, PAGE_HIT_LONG, 0);
    addStep("missLast",      STEP_EXPECT,  1,  'h200, 0, PAGE_MISS, 0);
    // --------------------
    // Old miss beats a fresh short hit
    addStep("holdAging",     STEP_IDLE,    0,  0,     0, 'h0000, 0);
    addStep("oldMiss",       STEP_PUSH,    1,  'h300, 0, 0, 0);
    addStep("aging",         STEP_WAIT,    0,  0,     0, 45, 0);
    addStep("youngHit",      STEP_PUSH,    0,  'h010, 0, 0, 0);
    addStep("releaseAging",  STEP_IDLE,    0,  0,     0, 'hFFFF, 0);
    addStep("agedMiss",      STEP_EXPECT,  1,  'h300, 0, PAGE_MISS, 0);
    addStep("youngHitIssue", STEP_EXPECT,  0,  'h010, 0, PAGE_HIT_SHORT, 0);
    // --------------------
    // Write mode where both queues see one open-row table
    addStep("holdMode",      STEP_IDLE,    0,  0,     0, 'h0000, 0);
    addStep("read7",         STEP_PUSH,    7,  'h050, 0, 0, 0);
    addStep("write7",        STEP_PUSH,    7,  'h050, 1, 0, 0);
    addStep("write10",       STEP_PUSH,    10, 'h030, 1, 0, 0);
    addStep("writeOn",       STEP_MODE,    0,  0,     0, 1, 0);
    addStep("releaseMode",   STEP_IDLE,    0,  0,     0, 'hFFFF, 0);
    addStep("writeHit",      STEP_EXPECT,  10, 'h030, 1, PAGE_HIT_LONG, 0);
    addStep("writeEmpty",    STEP_EXPECT,  7,  'h050, 1, PAGE_EMPTY, 0);
    addStep("readsHeld",     STEP_COUNTS,  0,  0,     0, 1, 0);
    addStep("writeOff",      STEP_MODE,    0,  0,     0, 0, 0);
    addStep("readHit",       STEP_EXPECT,  7,  'h050, 0, PAGE_HIT_SHORT, 0);
    // --------------------
    // Refresh whose acknowledge closes bank 7 again
    addStep("firstRefresh",  STEP_REFRESH, 0,  0,     0, 0, 0);
    addStep("lateRead",      STEP_PUSH,    7,  'h050, 0, 0, 0);
    addStep("blocked",       STEP_BLOCKED, 0,  0,     0, 8, 0);
    addStep("refreshAck",    STEP_ACK,     0,  0,     0, 0, 0);
    addStep("afterAck",      STEP_EXPECT,  7,  'h050, 0, PAGE_EMPTY, 0);
    addStep("nextRefresh",   STEP_REFRESH, 0,  0,     0, 0, 0);
endfunction

`endif

/* verification/rankSchedTb.sv */
`timescale 1ns/1ns

module rankSchedTb
    import dramGeometryPkg::*;
    import rankSchedPkg::*;
();

    localparam int ISSUE_TIMEOUT = 100;
    localparam int REFRESH_TIMEOUT = REFRESH_INTERVAL + 100;

    typedef enum logic [3:0] {
        STEP_PUSH, STEP_IDLE, STEP_MODE, STEP_WAIT, STEP_EXPECT,
        STEP_COUNTS, STEP_REFRESH, STEP_BLOCKED, STEP_ACK
    } stepKindT;

    // One table row
    typedef struct packed {
        stepKindT    kind;
        bankIndexT   bank;
        rowT         row;
        logic        write;
        logic [15:0] value;
        logic [15:0] aux;
    } stepT;

    // DUT ports
    logic                 clk;
    logic                 rst;
    logic                 reqValid;
    rankRequestT          request;
    logic                 writeMode;
    logic [NUM_BANKS-1:0] bankIdle;
    logic                 refreshAck;
    logic                 readReady;
    logic                 writeReady;
    queueCountT           readCount;
    queueCountT           writeCount;
    logic                 issueValid;
    issuedRequestT        issuedRequest;
    logic                 refresh;

    stepT  steps [$];
    string stepNames [$];

    // Reference open-row model
    logic [NUM_BANKS-1:0]        refOpen;
    rowT                         refRow [NUM_BANKS];
    logic [BANK_GROUP_WIDTH-1:0] refGroup;

    int cycleCount;
    int intervalStart;
    int issuesSeen;
    int issuesExpected;

    rankScheduler dut0 (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .request(request),
        .writeMode(writeMode),
        .bankIdle(bankIdle),
        .refreshAck(refreshAck),
        .readReady(readReady),
        .writeReady(writeReady),
        .readCount(readCount),
        .writeCount(writeCount),
        .issueValid(issueValid),
        .issuedRequest(issuedRequest),
        .refresh(refresh)
    );

    always #5 clk = ~clk;

    // Edges since reset release
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
        end
    end

    // Counts every issue pulse whether expected or not
    always @(negedge clk) begin
        if (issueValid) begin
            issuesSeen <= issuesSeen + 1;
        end
    end

    // --------------------
    // Helpers

    // Row, bank and bank group fields packed into a request address
    function automatic logic [ADDR_WIDTH-1:0] addressFor(bankIndexT bank, rowT row);
        logic [ADDR_WIDTH-1:0] rowBits;
        logic [ADDR_WIDTH-1:0] bankBits;
        logic [ADDR_WIDTH-1:0] groupBits;
        rowBits = ADDR_WIDTH'(row) << (ROW_LSB - ADDR_FIELD_BASE);
        bankBits = ADDR_WIDTH'(bank[BANK_WIDTH-1:0]) << (BANK_LSB - ADDR_FIELD_BASE);
        groupBits = ADDR_WIDTH'(bank[BANK_WIDTH +: BANK_GROUP_WIDTH])
            << (BANK_GROUP_LSB - ADDR_FIELD_BASE);
        return rowBits | bankBits | groupBits;
    endfunction

    // Page state the model predicts for a request
    function automatic pageStateT expectedPage(bankIndexT bank, rowT row);
        if (!refOpen[bank]) begin
            return PAGE_EMPTY;
        end else if (refRow[bank] != row) begin
            return PAGE_MISS;
        end else if (bank[BANK_WIDTH +: BANK_GROUP_WIDTH] == refGroup) begin
            return PAGE_HIT_SHORT;
        end
        return PAGE_HIT_LONG;
    endfunction

    function automatic void addStep(string name, stepKindT kind, int bank, int row,
                                    bit write, int value, int aux);
        stepT step;
        step.kind = kind;
        step.bank = bankIndexT'(bank);
        step.row = rowT'(row);
        step.write = write;
        step.value = 16'(value);
        step.aux = 16'(aux);
        steps.push_back(step);
        stepNames.push_back(name);
    endfunction

    `include "schedCases.svh"

    task automatic abortRun(string reason);
        $display("Error: %s", reason);
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic waitForIssue(string name);
        int waited;
        waited = 0;
        while (!issueValid) begin
            @(negedge clk);
            waited++;
            if (waited > ISSUE_TIMEOUT) begin
                abortRun({"step ", name, " saw no issue before its timeout"});
            end
        end
    endtask

    // Refresh must rise exactly one interval after the last start point
    task automatic waitForRefresh(string name);
        int waited;
        waited = 0;
        while (!refresh) begin
            @(negedge clk);
            waited++;
            if (waited > REFRESH_TIMEOUT) begin
                abortRun({"step ", name, " saw no refresh level before its timeout"});
            end
        end
        compareValue({name, " interval"}, REFRESH_INTERVAL, cycleCount - intervalStart);
    endtask

    // --------------------
    // Step execution entered on a falling edge

    task automatic runStep(int index);
        stepT  s;
        string name;
        s = steps[index];
        name = stepNames[index];
        case (s.kind)
            STEP_PUSH: begin
                // Never offer a request that cannot be taken
                compareValue({name, " ready"}, 32'(1), 32'(s.write ? writeReady : readReady));
                request = '0;
                request.address = addressFor(s.bank, s.row);
                request.write = s.write;
                // Side-band bits are tagged from the target bank and row
                request.id = s.row[4];
                request.user = USER_WIDTH'(s.bank);
                reqValid = 1'b1;
                @(negedge clk);
                reqValid = 1'b0;
            end
            STEP_IDLE: bankIdle = s.value;
            STEP_MODE: writeMode = s.value[0];
            STEP_WAIT: repeat (s.value) @(negedge clk);
            STEP_EXPECT: begin
                waitForIssue(name);
                compareValue({name, " address"}, addressFor(s.bank, s.row),
                             issuedRequest.request.address);
                compareValue({name, " write"}, 32'(s.write), 32'(issuedRequest.request.write));
                compareValue({name, " id"}, 32'(s.row[4]), 32'(issuedRequest.request.id));
                compareValue({name, " user"}, 32'(s.bank), 32'(issuedRequest.request.user));
                compareValue({name, " page"}, 32'(s.value), 32'(issuedRequest.pageState));
                compareValue({name, " model page"}, 32'(expectedPage(s.bank, s.row)),
                             32'(issuedRequest.pageState));
                // Issued bank is now open and sets the last bank group
                refOpen[s.bank] = 1'b1;
                refRow[s.bank] = s.row;
                refGroup = s.bank[BANK_WIDTH +: BANK_GROUP_WIDTH];
                issuesExpected++;
                @(negedge clk);
            end
            STEP_COUNTS: begin
                compareValue({name, " readCount"}, 32'(s.value), 32'(readCount));
                compareValue({name, " writeCount"}, 32'(s.aux), 32'(writeCount));
                compareValue({name, " readReady"}, 32'(s.value != QUEUE_DEPTH), 32'(readReady));
                compareValue({name, " writeReady"}, 32'(s.aux != QUEUE_DEPTH), 32'(writeReady));
            end
            STEP_REFRESH: waitForRefresh(name);
            STEP_BLOCKED: begin
                repeat (s.value) begin
                    compareValue({name, " refresh"}, 32'(1), 32'(refresh));
                    compareValue({name, " issueValid"}, 32'(0), 32'(issueValid));
                    @(negedge clk);
                end
            end
            STEP_ACK: begin
                refreshAck = 1'b1;
                @(negedge clk);
                refreshAck = 1'b0;
                intervalStart = cycleCount;
                // Refresh closes every bank
                refOpen = '0;
            end
            default: abortRun({"step ", name, " has an unknown kind"});
        endcase
    endtask

    // --------------------
    // Main sequence

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        reqValid = 1'b0;
        request = '0;
        writeMode = 1'b0;
        bankIdle = '0;
        refreshAck = 1'b0;
        refOpen = '0;
        refGroup = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            refRow[b] = '0;
        end
        intervalStart = 0;
        issuesSeen = 0;
        issuesExpected = 0;
        buildCaseTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            runStep(i);
        end
        // Catches issues that no step asked for
        compareValue("issue count", 32'(issuesExpected), 32'(issuesSeen));
        $display("Verification passed");
        $finish;
    end

endmodule

/* verilog/rankScheduler.sv */
`timescale 1ns/1ns

module rankScheduler
    import dramGeometryPkg::*;
    import rankSchedPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reqValid,
    input  rankRequestT          request,
    input  logic                 writeMode,
    input  logic [NUM_BANKS-1:0] bankIdle,
    input  logic                 refreshAck,
    output logic                 readReady,
    output logic                 writeReady,
    output queueCountT           readCount,
    output queueCountT           writeCount,
    output logic                 issueValid,
    output issuedRequestT        issuedRequest,
    output logic                 refresh
);

    // Frontend split by request type
    logic readPush;
    logic writePush;

    // Shared candidate bus
    queueCandidateT readCandidate;
    queueCandidateT writeCandidate;
    logic           readPop;
    logic           writePop;

    // Open-row view seen by both queues
    logic [NUM_BANKS-1:0]        openValid;
    rowT [NUM_BANKS-1:0]         openRow;
    logic [BANK_GROUP_WIDTH-1:0] lastBankGroup;

    assign readPush = reqValid && !request.write;
    assign writePush = reqValid && request.write;

    // --------------------
    // Request queues

    requestQueue readQueue0 (
        .clk(clk),
        .rst(rst),
        .push(readPush),
        .pushRequest(request),
        .pop(readPop),
        .popIndex(readCandidate.index),
        .bankIdle(bankIdle),
        .openValid(openValid),
        .openRow(openRow),
        .lastBankGroup(lastBankGroup),
        .notFull(readReady),
        .count(readCount),
        .candidate(readCandidate)
    );

    requestQueue writeQueue0 (
        .clk(clk),
        .rst(rst),
        .push(writePush),
        .pushRequest(request),
        .pop(writePop),
        .popIndex(writeCandidate.index),
        .bankIdle(bankIdle),
        .openValid(openValid),
        .openRow(openRow),
        .lastBankGroup(lastBankGroup),
        .notFull(writeReady),
        .count(writeCount),
        .candidate(writeCandidate)
    );

    // --------------------
    // Page tracking and refresh

    openRowTable openRowTable0 (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issuedRequest(issuedRequest),
        .refreshAck(refreshAck),
        .openValid(openValid),
        .openRow(openRow),
        .lastBankGroup(lastBankGroup)
    );

    refreshTimer refreshTimer0 (
        .clk(clk),
        .rst(rst),
        .refreshAck(refreshAck),
        .refresh(refresh)
    );

    // Issue path to the bank FSMs
    issueArbiter issueArbiter0 (
        .clk(clk),
        .rst(rst),
        .writeMode(writeMode),
        .refresh(refresh),
        .readCandidate(readCandidate),
        .writeCandidate(writeCandidate),
        .readPop(readPop),
        .writePop(writePop),
        .issueValid(issueValid),
        .issuedRequest(issuedRequest)
    );

endmodule

/* verilog/issueArbiter.sv */
`timescale 1ns/1ns

module issueArbiter
    import rankSchedPkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           writeMode,
    input  logic           refresh,
    input  queueCandidateT readCandidate,
    input  queueCandidateT writeCandidate,
    output logic           readPop,
    output logic           writePop,
    output logic           issueValid,
    output issuedRequestT  issuedRequest
);

    // Candidate of the queue that writeMode selects
    queueCandidateT selected;
    // Issue taken at this edge
    logic           grant;

    // --------------------
    // Grant

    always_comb begin
        if (writeMode) begin
            selected = writeCandidate;
        end else begin
            selected = readCandidate;
        end
    end

    // Refresh blocks every issue until it is acknowledged
    assign grant = selected.valid && !refresh;

    // Pop strobes land on the same edge as the issue register
    assign readPop = grant && !writeMode;
    assign writePop = grant && writeMode;

    // --------------------
    // Issue register

    // One-cycle pulse per issue, back to back allowed
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= grant;
        end
    end

    // Request and page state held until the next issue
    always_ff @(posedge clk) begin
        if (grant) begin
            issuedRequest.request <= selected.request;
            issuedRequest.pageState <= selected.pageState;
        end
    end

endmodule

/* verilog/refreshTimer.sv */
`timescale 1ns/1ns

module refreshTimer
    import rankSchedPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic refreshAck,
    output logic refresh
);

    // Cycles since reset release or the last acknowledge
    logic [REFRESH_COUNT_WIDTH-1:0] intervalCount;

    // --------------------
    // Interval counter

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            intervalCount <= '0;
            refresh <= 1'b0;
        end else if (refreshAck) begin
            // Refresh done, start a new interval
            refresh <= 1'b0;
            intervalCount <= '0;
        end else if (!refresh) begin
            if (intervalCount == REFRESH_COUNT_WIDTH'(REFRESH_INTERVAL - 1)) begin
                refresh <= 1'b1;
                intervalCount <= '0;
            end else begin
                intervalCount <= intervalCount + 1'b1;
            end
        end
        // Held while refresh is pending
    end

endmodule

/* verilog/openRowTable.sv */
`timescale 1ns/1ns

module openRowTable
    import dramGeometryPkg::*;
    import rankSchedPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  issuedRequestT               issuedRequest,
    input  logic                        refreshAck,
    output logic [NUM_BANKS-1:0]        openValid,
    output rowT [NUM_BANKS-1:0]         openRow,
    output logic [BANK_GROUP_WIDTH-1:0] lastBankGroup
);

    // Stored table, one issue behind the outputs
    logic [NUM_BANKS-1:0]        validReg;
    rowT [NUM_BANKS-1:0]         rowReg;
    logic [BANK_GROUP_WIDTH-1:0] groupReg;

    bankIndexT                   issuedBank;
    rowT                         issuedRow;
    logic [BANK_GROUP_WIDTH-1:0] issuedGroup;

    assign issuedBank = bankOf(issuedRequest.request.address);
    assign issuedRow = rowOf(issuedRequest.request.address);
    assign issuedGroup = bankGroupOf(issuedRequest.request.address);

    // --------------------
    // Table update

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validReg <= '0;
            groupReg <= '0;
        end else begin
            // Refresh closes every page, including one opened by the pending issue
            if (refreshAck) begin
                validReg <= '0;
            end else if (issueValid) begin
                validReg[issuedBank] <= 1'b1;
            end
            if (issueValid) begin
                groupReg <= issuedGroup;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            rowReg[issuedBank] <= issuedRow;
        end
    end

    // Issue in flight is already visible, as if taken at the issue edge
    always_comb begin
        openValid = validReg;
        openRow = rowReg;
        lastBankGroup = groupReg;
        if (issueValid) begin
            openValid[issuedBank] = 1'b1;
            openRow[issuedBank] = issuedRow;
            lastBankGroup = issuedGroup;
        end
    end

endmodule

/* verilog/requestQueue.sv */
`timescale 1ns/1ns

module requestQueue
    import dramGeometryPkg::*;
    import rankSchedPkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  rankRequestT                 pushRequest,
    input  logic                        pop,
    input  queueIndexT                  popIndex,
    input  logic [NUM_BANKS-1:0]        bankIdle,
    input  logic [NUM_BANKS-1:0]        openValid,
    input  rowT [NUM_BANKS-1:0]         openRow,
    input  logic [BANK_GROUP_WIDTH-1:0] lastBankGroup,
    output logic                        notFull,
    output queueCountT                  count,
    output queueCandidateT              candidate
);

    // Payload slots and their ages
    rankRequestT          entry [QUEUE_DEPTH];
    logic [AGE_WIDTH-1:0] age [QUEUE_DEPTH];
    // 1 marks a free slot
    logic [QUEUE_DEPTH-1:0] freeMap;
    logic [QUEUE_DEPTH-1:0] eligible;
    pageStateT            slotState [QUEUE_DEPTH];

    queueIndexT pushIndex;
    logic       doPush;

    // Search results
    logic                 anyAged;
    logic                 oldestFound;
    queueIndexT           oldestIndex;
    logic [AGE_WIDTH-1:0] oldestAge;
    logic                 shortFound;
    queueIndexT           shortIndex;
    logic                 longFound;
    queueIndexT           longIndex;
    queueIndexT           winner;

    // Page state of a request against the open-row inputs
    function automatic pageStateT classify(rankRequestT req);
        bankIndexT bank;
        bank = bankOf(req.address);
        if (!openValid[bank]) begin
            return PAGE_EMPTY;
        end
        if (openRow[bank] != rowOf(req.address)) begin
            return PAGE_MISS;
        end
        // Same bank group as the last issue means short tCCD
        return (bankGroupOf(req.address) == lastBankGroup) ? PAGE_HIT_SHORT : PAGE_HIT_LONG;
    endfunction

    // --------------------
    // Slot allocation

    assign notFull = |freeMap;
    assign doPush = push && notFull;

    // Lowest free slot
    always_comb begin
        pushIndex = '0;
        for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (freeMap[i]) begin
                pushIndex = queueIndexT'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entry[pushIndex] <= pushRequest;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            freeMap <= '1;
            count <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            // Occupied slots age until they saturate
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (!freeMap[i] && (age[i] != '1)) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
            if (doPush) begin
                freeMap[pushIndex] <= 1'b0;
            end
            // Freed slot starts again from age zero
            if (pop) begin
                freeMap[popIndex] <= 1'b1;
                age[popIndex] <= '0;
            end
            case ({doPush, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // FR-FCFS search

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            slotState[i] = classify(entry[i]);
            // Only occupied slots whose bank is idle compete
            eligible[i] = !freeMap[i] && bankIdle[bankOf(entry[i].address)];
        end
    end

    // Ascending scan, so lowest index wins every tie
    always_comb begin
        anyAged = 1'b0;
        oldestFound = 1'b0;
        oldestIndex = '0;
        oldestAge = '0;
        shortFound = 1'b0;
        shortIndex = '0;
        longFound = 1'b0;
        longIndex = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (eligible[i]) begin
                if (age[i] > AGE_THRESHOLD) begin
                    anyAged = 1'b1;
                end
                if (!oldestFound || (age[i] > oldestAge)) begin
                    oldestFound = 1'b1;
                    oldestIndex = queueIndexT'(i);
                    oldestAge = age[i];
                end
                if (!shortFound && (slotState[i] == PAGE_HIT_SHORT)) begin
                    shortFound = 1'b1;
                    shortIndex = queueIndexT'(i);
                end
                if (!longFound && (slotState[i] == PAGE_HIT_LONG)) begin
                    longFound = 1'b1;
                    longIndex = queueIndexT'(i);
                end
            end
        end
    end

    // Starvation guard first, then short hit, long hit, oldest
    always_comb begin
        if (anyAged) begin
            winner = oldestIndex;
        end else if (shortFound) begin
            winner = shortIndex;
        end else if (longFound) begin
            winner = longIndex;
        end else begin
            winner = oldestIndex;
        end
        candidate.valid = oldestFound;
        candidate.index = winner;
        candidate.request = entry[winner];
        candidate.pageState = slotState[winner];
    end

endmodule

/* verilog/rankSchedPkg.sv */
package rankSchedPkg;

    import dramGeometryPkg::*;

    // --------------------
    // Queue sizing

    localparam int QUEUE_DEPTH = 8;
    typedef logic [$clog2(QUEUE_DEPTH)-1:0] queueIndexT;
    // One extra bit so a full queue of 8 fits
    typedef logic [$clog2(QUEUE_DEPTH):0] queueCountT;

    // Aging, saturates at all ones
    localparam int AGE_WIDTH = 10;
    // Oldest-first takes over once an eligible age is above this
    localparam int AGE_THRESHOLD = 40;

    // --------------------
    // Refresh

    // Cycles from reset release or acknowledge to the refresh level
    localparam int REFRESH_INTERVAL = 2000;
    localparam int REFRESH_COUNT_WIDTH = $clog2(REFRESH_INTERVAL);

    // Request side-band
    localparam int ID_WIDTH = 1;
    localparam int USER_WIDTH = 4;

    // Page state of a request against the open-row table
    typedef enum logic [1:0] {
        PAGE_HIT_SHORT = 2'd0,
        PAGE_HIT_LONG  = 2'd1,
        PAGE_MISS      = 2'd2,
        PAGE_EMPTY     = 2'd3
    } pageStateT;

    // --------------------
    // Request records

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic                  write;
        logic [ID_WIDTH-1:0]   id;
        logic [USER_WIDTH-1:0] user;
    } rankRequestT;

    // Nominee of one queue
    typedef struct packed {
        logic        valid;
        queueIndexT  index;
        rankRequestT request;
        pageStateT   pageState;
    } queueCandidateT;

    typedef struct packed {
        rankRequestT request;
        pageStateT   pageState;
    } issuedRequestT;

endpackage

/* verilog/dramGeometryPkg.sv */
package dramGeometryPkg;

    // Request address of one rank
    localparam int ADDR_WIDTH = 32;

    // Field positions count in the 48-bit queue entry frame
    // The request address starts at bit 16 of that frame
    localparam int ADDR_FIELD_BASE = 16;

    localparam int ROW_WIDTH = 15;
    localparam int ROW_LSB = 22;
    localparam int BANK_WIDTH = 2;
    localparam int BANK_LSB = 37;
    localparam int BANK_GROUP_WIDTH = 2;
    localparam int BANK_GROUP_LSB = 39;

    // Four bank groups of four banks
    localparam int NUM_BANKS = 2 ** (BANK_GROUP_WIDTH + BANK_WIDTH);

    // Bank group in the upper bits, bank in the lower bits
    typedef logic [BANK_GROUP_WIDTH+BANK_WIDTH-1:0] bankIndexT;
    typedef logic [ROW_WIDTH-1:0] rowT;

    // --------------------
    // Field extraction

    function automatic rowT rowOf(logic [ADDR_WIDTH-1:0] address);
        return address[ROW_LSB-ADDR_FIELD_BASE +: ROW_WIDTH];
    endfunction

    function automatic logic [BANK_GROUP_WIDTH-1:0] bankGroupOf(logic [ADDR_WIDTH-1:0] address);
        return address[BANK_GROUP_LSB-ADDR_FIELD_BASE +: BANK_GROUP_WIDTH];
    endfunction

    function automatic bankIndexT bankOf(logic [ADDR_WIDTH-1:0] address);
        return {bankGroupOf(address), address[BANK_LSB-ADDR_FIELD_BASE +: BANK_WIDTH]};
    endfunction

    // Builds an address from a combined bank index and a row
    function automatic logic [ADDR_WIDTH-1:0] makeAddress(bankIndexT bank, rowT row);
        logic [ADDR_WIDTH-1:0] address;
        address = '0;
        address[ROW_LSB-ADDR_FIELD_BASE +: ROW_WIDTH] = row;
        address[BANK_LSB-ADDR_FIELD_BASE +: BANK_WIDTH] = bank[BANK_WIDTH-1:0];
        address[BANK_GROUP_LSB-ADDR_FIELD_BASE +: BANK_GROUP_WIDTH] =
            bank[BANK_WIDTH +: BANK_GROUP_WIDTH];
        return address;
    endfunction

endpackage
